// File: include/uart_defs.svh
// UART build options
// Frame layout, parity sense and status counter width
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// Payload bits per frame
`define UART_DATA_BITS 8

// Start + data + parity + stop
`define UART_FRAME_BITS 11

// Parity sense, 1'b0 even, 1'b1 odd
// Parity bit makes ones over data plus parity even (or odd)
`define UART_PARITY_ODD 1'b0

// Width of each saturating status counter
`define UART_COUNT_W 8

`endif

// File: hdl/uart_pkg.sv
// Shared UART types
// Data byte, frame bit index, counter value
// Transmit and receive FSM state encodings
`include "uart_defs.svh"

package uart_pkg;

    // One payload byte
    typedef logic [`UART_DATA_BITS-1:0] uart_byte_t;

    // Position inside a frame, counts up to 10
    typedef logic [3:0] bit_idx_t;

    // Status counter value
    typedef logic [`UART_COUNT_W-1:0] count_t;

    // Transmitter FSM
    typedef enum logic {
        TX_IDLE,  // Line high, waiting for start_tx
        TX_SHIFT  // Start, data, parity, stop on the line
    } tx_state_t;

    // Receiver FSM
    typedef enum logic {
        RX_IDLE,  // Hunting for a low start bit
        RX_SHIFT  // Sampling data, parity, stop
    } rx_state_t;

endpackage

// File: hdl/uart_tx.sv
// UART frame serializer, one bit per baud_clk
// Start bit, data LSB first, parity, stop bit
// Registered busy level and end-of-frame pulse
`timescale 1ns/1ps
`include "uart_defs.svh"

module uart_tx (
    input  logic                 baud_clk,
    input  logic                 arst_n,
    input  uart_pkg::uart_byte_t tx_data,   // Sampled only at the accepting edge
    input  logic                 start_tx,  // Level request
    output logic                 tx,        // Serial line, idles high
    output logic                 tx_busy,   // Frame in progress
    output logic                 tx_done    // High during the stop bit cycle
);

    import uart_pkg::*;

    localparam bit_idx_t PAR_IDX  = bit_idx_t'(`UART_FRAME_BITS - 2); // Parity on line
    localparam bit_idx_t STOP_IDX = bit_idx_t'(`UART_FRAME_BITS - 1); // Stop on line

    tx_state_t                   state_q;
    bit_idx_t                    bit_idx_q;  // Bits already presented after start
    logic [`UART_FRAME_BITS-2:0] shift_q;    // {stop, parity, data}
    logic                        parity;     // Parity of incoming byte
    logic                        frame_end;  // Stop bit ends at this edge
    logic                        accept;     // Load a new frame at this edge

    assign parity    = (^tx_data) ^ `UART_PARITY_ODD; // Inverted for odd sense
    assign frame_end = (state_q == TX_SHIFT) && (bit_idx_q == STOP_IDX);
    // Back to back allowed at the closing edge
    assign accept    = start_tx && ((state_q == TX_IDLE) || frame_end);

    // Control path
    always_ff @(posedge baud_clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= TX_IDLE;
            bit_idx_q <= '0;
            tx        <= 1'b1;  // Idle line
            tx_busy   <= 1'b0;
            tx_done   <= 1'b0;
        end else begin
            tx_done <= 1'b0;  // Pulse by default low
            if (accept) begin
                state_q   <= TX_SHIFT;
                bit_idx_q <= '0;
                tx        <= 1'b0;  // Start bit
                tx_busy   <= 1'b1;
            end else if (frame_end) begin
                state_q <= TX_IDLE;
                tx      <= 1'b1;  // Hold line high
                tx_busy <= 1'b0;
            end else if (state_q == TX_SHIFT) begin
                tx        <= shift_q[0];              // Next bit, LSB first
                bit_idx_q <= bit_idx_q + 1'b1;
                tx_done   <= (bit_idx_q == PAR_IDX);  // Stop bit goes out now
            end
        end
    end

    // Frame shifter, payload only
    always_ff @(posedge baud_clk) begin
        if (accept) begin
            shift_q <= {1'b1, parity, tx_data};  // Stop, parity, data
        end else if (state_q == TX_SHIFT) begin
            shift_q <= {1'b1, shift_q[`UART_FRAME_BITS-2:1]};  // Fill with ones
        end
    end

endmodule

// File: hdl/uart_rx.sv
// UART frame deserializer, one sample per baud_clk
// Start detect, data LSB first, parity and stop check
// Result byte and error flags with a one-cycle valid
`timescale 1ns/1ps
`include "uart_defs.svh"

module uart_rx (
    input  logic                 baud_clk,
    input  logic                 arst_n,
    input  logic                 rx,             // Serial line, synchronous to baud_clk
    output uart_pkg::uart_byte_t rx_data,        // Held until next rx_valid
    output logic                 rx_valid,       // One-cycle pulse per frame
    output logic                 rx_parity_err,  // Parity mismatch on last frame
    output logic                 rx_frame_err    // Stop bit low on last frame
);

    import uart_pkg::*;

    localparam bit_idx_t PAR_IDX  = bit_idx_t'(`UART_DATA_BITS);      // Parity sample
    localparam bit_idx_t STOP_IDX = bit_idx_t'(`UART_DATA_BITS + 1);  // Stop sample

    rx_state_t  state_q;
    bit_idx_t   bit_idx_q;   // Bits sampled after start
    uart_byte_t shift_q;     // Data assembly, fills from MSB
    logic       par_acc_q;   // Running XOR of data and parity
    logic       data_phase;  // Sampling a data bit
    logic       par_phase;   // Sampling the parity bit
    logic       stop_phase;  // Sampling the stop bit

    assign data_phase = (state_q == RX_SHIFT) && (bit_idx_q < PAR_IDX);
    assign par_phase  = (state_q == RX_SHIFT) && (bit_idx_q == PAR_IDX);
    assign stop_phase = (state_q == RX_SHIFT) && (bit_idx_q == STOP_IDX);

    // Control and status flags
    always_ff @(posedge baud_clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q       <= RX_IDLE;
            bit_idx_q     <= '0;
            rx_valid      <= 1'b0;
            rx_parity_err <= 1'b0;
            rx_frame_err  <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state_q)
                RX_IDLE: begin
                    if (!rx) begin  // Start bit seen
                        state_q   <= RX_SHIFT;
                        bit_idx_q <= '0;
                    end
                end
                RX_SHIFT: begin
                    if (stop_phase) begin
                        state_q       <= RX_IDLE;  // Ready on next edge
                        rx_valid      <= 1'b1;
                        // Ones count must match parity sense
                        rx_parity_err <= par_acc_q ^ `UART_PARITY_ODD;
                        rx_frame_err  <= ~rx;      // Stop must be high
                    end else begin
                        bit_idx_q <= bit_idx_q + 1'b1;
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    // Payload path
    always_ff @(posedge baud_clk) begin
        if (state_q == RX_IDLE) begin
            par_acc_q <= 1'b0;  // Fresh parity per frame
        end else if (data_phase || par_phase) begin
            par_acc_q <= par_acc_q ^ rx;
        end
        if (data_phase) begin
            shift_q <= {rx, shift_q[`UART_DATA_BITS-1:1]};  // LSB arrives first
        end
        if (stop_phase) begin
            rx_data <= shift_q;  // Publish with valid
        end
    end

endmodule

// File: hdl/link_status.sv
// Link status counters
// Frames sent, frames received, parity and stop errors
// All counters saturate at all ones
`timescale 1ns/1ps

module link_status (
    input  logic             baud_clk,
    input  logic             arst_n,
    input  logic             tx_done,           // Transmit frame finished
    input  logic             rx_valid,          // Receive frame finished
    input  logic             rx_parity_err,     // Qualified by rx_valid
    input  logic             rx_frame_err,      // Qualified by rx_valid
    output uart_pkg::count_t tx_count,
    output uart_pkg::count_t rx_count,
    output uart_pkg::count_t parity_err_count,
    output uart_pkg::count_t frame_err_count
);

    import uart_pkg::*;

    logic par_evt;    // Received frame with bad parity
    logic frame_evt;  // Received frame with bad stop bit

    // Step by one unless already full
    function automatic count_t sat_inc(input count_t value, input logic hit);
        count_t next_value;
        next_value = value;
        if (hit && (value != '1)) begin
            next_value = value + 1'b1;
        end
        return next_value;
    endfunction

    assign par_evt   = rx_valid && rx_parity_err;
    assign frame_evt = rx_valid && rx_frame_err;

    // Transmit side
    always_ff @(posedge baud_clk or negedge arst_n) begin
        if (!arst_n) begin
            tx_count <= '0;
        end else begin
            tx_count <= sat_inc(tx_count, tx_done);
        end
    end

    // Receive side, one view of both error kinds
    always_ff @(posedge baud_clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_count         <= '0;
            parity_err_count <= '0;
            frame_err_count  <= '0;
        end else begin
            rx_count         <= sat_inc(rx_count, rx_valid);  // Good and bad frames
            parity_err_count <= sat_inc(parity_err_count, par_evt);
            frame_err_count  <= sat_inc(frame_err_count, frame_evt);
        end
    end

endmodule

// File: hdl/uart_link.sv
// UART link top level
// Transmitter and receiver side by side
// Status counters fed from both directions
`timescale 1ns/1ps

module uart_link (
    input  logic                 baud_clk,
    input  logic                 arst_n,
    // Transmit side
    input  uart_pkg::uart_byte_t tx_data,
    input  logic                 start_tx,
    output logic                 tx,
    output logic                 tx_busy,
    // Receive side
    input  logic                 rx,
    output uart_pkg::uart_byte_t rx_data,
    output logic                 rx_valid,
    output logic                 rx_parity_err,
    output logic                 rx_frame_err,
    // Status
    output uart_pkg::count_t     tx_count,
    output uart_pkg::count_t     rx_count,
    output uart_pkg::count_t     parity_err_count,
    output uart_pkg::count_t     frame_err_count
);

    logic tx_done;  // End of transmitted frame, internal only

    uart_tx u_tx (
        .baud_clk (baud_clk),
        .arst_n   (arst_n),
        .tx_data  (tx_data),
        .start_tx (start_tx),
        .tx       (tx),
        .tx_busy  (tx_busy),
        .tx_done  (tx_done)
    );

    uart_rx u_rx (
        .baud_clk      (baud_clk),
        .arst_n        (arst_n),
        .rx            (rx),
        .rx_data       (rx_data),
        .rx_valid      (rx_valid),
        .rx_parity_err (rx_parity_err),
        .rx_frame_err  (rx_frame_err)
    );

    link_status u_status (
        .baud_clk         (baud_clk),
        .arst_n           (arst_n),
        .tx_done          (tx_done),
        .rx_valid         (rx_valid),
        .rx_parity_err    (rx_parity_err),
        .rx_frame_err     (rx_frame_err),
        .tx_count         (tx_count),
        .rx_count         (rx_count),
        .parity_err_count (parity_err_count),
        .frame_err_count  (frame_err_count)
    );

endmodule

// File: sim/tb_uart_link.sv
// Self-checking testbench for the UART link
// Vectors read from a hex data file, loopback or injected frames
// Checks line shape, latency, receive flags and status counters
`timescale 1ns/1ps
`include "uart_defs.svh"

module tb_uart_link;

    import uart_pkg::*;

    localparam int MAX_VECTORS = 64;
    localparam int WAIT_LIMIT  = 40;  // Cycles before a wait gives up
    localparam int HOLD_CYCLES = 3;   // start_tx stays high into the frame
    localparam int COUNT_MAX   = (1 << `UART_COUNT_W) - 1;

    typedef logic [`UART_FRAME_BITS-1:0] frame_t;

    logic       baud_clk;
    logic       arst_n;
    uart_byte_t tx_data;
    logic       start_tx;
    logic       tx_line;
    logic       tx_busy;
    logic       rx_drv;       // Serial line driven by the testbench
    logic       rx_line;      // Line seen by the receiver
    logic       inject_mode;  // 1 selects rx_drv, 0 loops tx back
    uart_byte_t rx_data;
    logic       rx_valid;
    logic       rx_parity_err;
    logic       rx_frame_err;
    count_t     tx_count;
    count_t     rx_count;
    count_t     parity_err_count;
    count_t     frame_err_count;

    logic [19:0] vectors [0:MAX_VECTORS-1];  // Nibbles: mode, byte, bad parity, bad stop

    int checks;
    int value_errors;
    int other_errors;  // Timeouts and file problems
    int tx_total;      // Tallies from the vectors
    int rx_total;
    int par_total;
    int stop_total;

    always #10 baud_clk = ~baud_clk;  // 20 ns bit period

    assign rx_line = inject_mode ? rx_drv : tx_line;  // Loopback mux

    uart_link dut_i (
        .baud_clk         (baud_clk),
        .arst_n           (arst_n),
        .tx_data          (tx_data),
        .start_tx         (start_tx),
        .tx               (tx_line),
        .tx_busy          (tx_busy),
        .rx               (rx_line),
        .rx_data          (rx_data),
        .rx_valid         (rx_valid),
        .rx_parity_err    (rx_parity_err),
        .rx_frame_err     (rx_frame_err),
        .tx_count         (tx_count),
        .rx_count         (rx_count),
        .parity_err_count (parity_err_count),
        .frame_err_count  (frame_err_count)
    );

    // Frame as it appears on the line, bit 0 first
    function automatic frame_t build_frame(input uart_byte_t value, input logic flip_par,
                                           input logic low_stop);
        frame_t bits;
        int     ones;
        int     i;
        logic   par;
        ones = 0;
        for (i = 0; i < `UART_DATA_BITS; i++) begin
            ones = ones + value[i];
        end
        // Even sense wants an even total of ones, odd sense an odd one
        par = ((ones % 2) == 1) ? !`UART_PARITY_ODD : `UART_PARITY_ODD;
        bits[0]                   = 1'b0;             // Start
        bits[`UART_DATA_BITS:1]   = value;            // LSB first
        bits[`UART_DATA_BITS+1]   = par ^ flip_par;
        bits[`UART_DATA_BITS+2]   = !low_stop;        // Stop
        return bits;
    endfunction

    // Counters stop at all ones
    function automatic int limit_count(input int total);
        return (total > COUNT_MAX) ? COUNT_MAX : total;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            value_errors++;
            $display("FAIL %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic check_seen(input string what, input logic seen);
        assert (seen) else begin
            other_errors++;
            $display("Timed out after %0d cycles waiting for %s", WAIT_LIMIT, what);
        end
    endtask

    task automatic check_counters(input string name);
        check_value({name, " tx_count"}, limit_count(tx_total), tx_count);
        check_value({name, " rx_count"}, limit_count(rx_total), rx_count);
        check_value({name, " parity_err_count"}, limit_count(par_total), parity_err_count);
        check_value({name, " frame_err_count"}, limit_count(stop_total), frame_err_count);
    endtask

    task automatic run_loopback(input int vec, input uart_byte_t value);
        string  name;
        frame_t expect_line;
        frame_t line_bits;
        int     k;
        logic   seen;
        name        = $sformatf("vector %0d loopback %02h", vec, value);
        expect_line = build_frame(value, 1'b0, 1'b0);
        line_bits   = 'x;
        inject_mode = 1'b0;
        tx_data     = value;
        start_tx    = 1'b1;
        k           = 0;
        seen        = 1'b0;
        while (!seen && k < WAIT_LIMIT) begin  // Look for the accepting edge
            @(negedge baud_clk);
            k++;
            seen = tx_busy;
        end
        check_seen("tx_busy", seen);
        check_value({name, " accept edges"}, 1, k);
        tx_data      = ~value;   // Byte is latched already
        line_bits[0] = tx_line;  // Start bit
        k            = 0;
        seen         = 1'b0;
        while (!seen && k < WAIT_LIMIT) begin
            @(negedge baud_clk);
            k++;
            if (k == HOLD_CYCLES) begin
                start_tx = 1'b0;  // Held while busy, must start nothing
            end
            if (k < `UART_FRAME_BITS) begin
                line_bits[k] = tx_line;
            end
            seen = rx_valid;
        end
        start_tx = 1'b0;
        check_seen("rx_valid", seen);
        check_value({name, " valid edges"}, `UART_FRAME_BITS, k);
        check_value({name, " tx line"}, expect_line, line_bits);
        check_value({name, " rx_data"}, value, rx_data);
        check_value({name, " rx_parity_err"}, 0, rx_parity_err);
        check_value({name, " rx_frame_err"}, 0, rx_frame_err);
        check_value({name, " tx_busy"}, 0, tx_busy);
        tx_total++;
        rx_total++;
        @(negedge baud_clk);  // Counters move one cycle after the pulse
        check_counters(name);
    endtask

    task automatic run_inject(input int vec, input uart_byte_t value, input logic bad_par,
                              input logic bad_stop);
        string  name;
        frame_t bits;
        int     i;
        int     k;
        logic   seen;
        name        = $sformatf("vector %0d inject %02h", vec, value);
        bits        = build_frame(value, bad_par, bad_stop);
        inject_mode = 1'b1;
        for (i = 0; i < `UART_FRAME_BITS; i++) begin
            rx_drv = bits[i];  // Sampled at the next rising edge
            @(negedge baud_clk);
        end
        rx_drv = 1'b1;  // Idle line
        k      = 0;
        seen   = rx_valid;
        while (!seen && k < WAIT_LIMIT) begin
            @(negedge baud_clk);
            k++;
            seen = rx_valid;
        end
        check_seen("rx_valid", seen);
        check_value({name, " rx_data"}, value, rx_data);
        check_value({name, " rx_parity_err"}, bad_par, rx_parity_err);
        check_value({name, " rx_frame_err"}, bad_stop, rx_frame_err);
        rx_total++;
        par_total  = par_total + bad_par;
        stop_total = stop_total + bad_stop;
        @(negedge baud_clk);
        check_value({name, " rx_valid width"}, 0, rx_valid);  // One-cycle pulse
        check_counters(name);
    endtask

    initial begin
        int         seed;
        int         idx;
        int         gap;
        logic [3:0] mode;
        uart_byte_t value;
        logic       bad_par;
        logic       bad_stop;
        seed        = $urandom(50);  // Idle gaps only
        baud_clk    = 1'b0;
        arst_n      = 1'b0;
        tx_data     = '0;
        start_tx    = 1'b0;
        rx_drv      = 1'b1;
        inject_mode = 1'b0;
        checks       = 0;
        value_errors = 0;
        other_errors = 0;
        tx_total     = 0;
        rx_total     = 0;
        par_total    = 0;
        stop_total   = 0;
        $readmemh("sim/uart_input.txt", vectors);
        repeat (8) @(negedge baud_clk);
        arst_n = 1'b1;
        @(negedge baud_clk);
        check_value("reset tx", 1, tx_line);
        check_value("reset tx_busy", 0, tx_busy);
        check_value("reset rx_valid", 0, rx_valid);
        check_value("reset rx_parity_err", 0, rx_parity_err);
        check_value("reset rx_frame_err", 0, rx_frame_err);
        check_counters("reset");
        idx = 0;
        while (idx < MAX_VECTORS && !$isunknown(vectors[idx])) begin
            mode     = vectors[idx][19:16];
            value    = vectors[idx][15:8];
            bad_par  = vectors[idx][4];
            bad_stop = vectors[idx][0];
            if (mode == 4'h0) begin
                run_loopback(idx, value);
            end else begin
                run_inject(idx, value, bad_par, bad_stop);
            end
            gap = $urandom % 4;  // Idle cycles between frames
            repeat (gap) @(negedge baud_clk);
            idx++;
        end
        assert (idx > 0) else begin
            other_errors++;
            $display("No test vectors were read from the input file");
        end
        check_counters("final");
        $display("Checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: sim/uart_input.txt
// Columns as hex nibbles: mode_byte_badparity_badstop
// Mode 0 loops tx back to rx, mode 1 injects on rx, flag 1 corrupts the frame
0_a5_0_0
0_00_0_0
0_ff_0_0
0_5a_0_0
0_01_0_0
0_80_0_0
1_3c_0_0
1_3c_1_0
1_c3_0_1
1_7e_1_1
0_96_0_0
1_00_1_0
1_ff_0_1
0_69_0_0
1_55_0_0
1_aa_1_0
0_3c_0_0
1_81_0_1

// File: vlog.f
+incdir+include
hdl/uart_pkg.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/link_status.sv
hdl/uart_link.sv
sim/tb_uart_link.sv

// File: Bender.yml
package:
  name: uart_link

export_include_dirs:
  - include

sources:
  - hdl/uart_pkg.sv
  - hdl/uart_tx.sv
  - hdl/uart_rx.sv
  - hdl/link_status.sv
  - hdl/uart_link.sv
  - target: simulation
    files:
      - sim/tb_uart_link.sv
